// ==== common/bench_regs_pkg.sv ====
/*
 * control bus widths, register map and ctrl bit positions
 * AXI4-Lite response codes and control FSM state types
 */
package bench_regs_pkg;

  localparam int axi_addr_width = 12;
  localparam int axi_data_width = 32;
  localparam int axi_strb_width = 4;

  // register map
  localparam logic [axi_addr_width-1:0] reg_ctrl           = 12'h000;
  localparam logic [axi_addr_width-1:0] reg_time_in_cycles = 12'h010;
  localparam logic [axi_addr_width-1:0] reg_exec_cycles    = 12'h014;
  localparam logic [axi_addr_width-1:0] reg_stat_base      = 12'h040;  // 4 bytes per statistic

  // reg_ctrl fields
  localparam int ctrl_start_bit = 0;  // write 1 to start
  localparam int ctrl_done_bit  = 1;  // sticky, clear on read
  localparam int ctrl_idle_bit  = 2;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

endpackage

// ==== common/stat_bus_if.sv ====
/*
 * stats bus between event tap, counters and control slave
 */
`timescale 1ns/10ps

interface stat_bus_if import tcp_stats_pkg::*; ();

  logic                  clear;                   // start pulse
  logic [num_stats-1:0]  inc_en;
  logic [stat_width-1:0] inc_amount [num_stats];
  logic [stat_width-1:0] count      [num_stats];

  modport tap (
    output inc_en,
    output inc_amount
  );

  modport counter (
    input  clear,
    input  inc_en,
    input  inc_amount,
    output count
  );

  modport reader (
    output clear,
    input  count
  );

endinterface

// ==== common/tcp_stats_pkg.sv ====
/*
 * statistic indices and counter width
 * field positions in the monitored TCP streams
 */
package tcp_stats_pkg;

  localparam int stat_width     = 32;
  localparam int num_stats      = 13;
  localparam int stat_idx_width = $clog2(num_stats);

  typedef enum logic [stat_idx_width-1:0] {
    STAT_LISTEN_REQ,
    STAT_OPEN_REQ,
    STAT_OPEN_STS,
    STAT_OPEN_OK,
    STAT_CLOSE_REQ,
    STAT_RD_REQ_BYTES,
    STAT_RX_PKTS,
    STAT_RX_BYTES,
    STAT_TX_BYTES,
    STAT_TX_PKTS,
    STAT_TX_CMDS,
    STAT_TX_STS,
    STAT_TX_STS_GOOD
  } stat_id_e;

  localparam int keep_width     = 8;
  localparam int open_sts_width = 24;
  localparam int open_ok_bit    = 16;  // connection established
  localparam int rd_req_width   = 32;
  localparam int rd_len_lsb     = 16;  // length in [31:16]
  localparam int tx_sts_width   = 64;
  localparam int tx_err_msb     = 63;
  localparam int tx_err_lsb     = 62;

endpackage

// ==== control/control_s_axi.sv ====
/*
 * AXI4-Lite control slave: write and read FSMs, run length register,
 * start pulse, sticky done and idle status, statistics readback
 */
`timescale 1ns/10ps

module control_s_axi import bench_regs_pkg::*, tcp_stats_pkg::*; (
  input  logic                      ap_clk,
  input  logic                      ap_rst_n,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [axi_addr_width-1:0] awaddr,
  input  logic                      wvalid,
  output logic                      wready,
  input  logic [axi_data_width-1:0] wdata,
  input  logic [axi_strb_width-1:0] wstrb,
  output logic                      bvalid,
  input  logic                      bready,
  output logic [1:0]                bresp,
  input  logic                      arvalid,
  output logic                      arready,
  input  logic [axi_addr_width-1:0] araddr,
  output logic                      rvalid,
  input  logic                      rready,
  output logic [axi_data_width-1:0] rdata,
  output logic [1:0]                rresp,
  input  logic                      done,
  input  logic [axi_data_width-1:0] exec_cycles,
  output logic                      start_pulse,
  output logic [axi_data_width-1:0] time_in_cycles,
  stat_bus_if.reader                stats
);

  wr_state_e                 wr_state;
  rd_state_e                 rd_state;
  logic                      wr_fire;
  logic                      rd_fire;
  logic                      ap_done_r;
  logic                      ap_idle_r;
  logic                      stat_hit;
  logic [axi_addr_width-1:0] stat_off;
  logic [axi_data_width-1:0] rd_mux;
  logic [axi_data_width-1:0] rdata_r;

  // write channel, address and data taken together
  assign awready = (wr_state == WR_IDLE) && awvalid && wvalid;
  assign wready  = awready;
  assign wr_fire = awready;
  assign bvalid  = (wr_state == WR_RESP);
  assign bresp   = OKAY;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (wr_fire) wr_state <= WR_RESP;
        WR_RESP: if (bready) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_pulse    <= 1'b0;
      time_in_cycles <= '0;
    end else begin
      start_pulse <= wr_fire && (awaddr == reg_ctrl) &&
                     wstrb[0] && wdata[ctrl_start_bit];  // one cycle wide
      if (wr_fire && (awaddr == reg_time_in_cycles)) begin
        for (int b = 0; b < axi_strb_width; b++) begin
          if (wstrb[b]) time_in_cycles[8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  assign stats.clear = start_pulse;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      ap_done_r <= 1'b0;
      ap_idle_r <= 1'b1;
    end else begin
      if (done) ap_done_r <= 1'b1;
      else if (rd_fire && (araddr == reg_ctrl)) ap_done_r <= 1'b0;  // clear on read
      if (start_pulse) ap_idle_r <= 1'b0;  // restart wins, as in the timer
      else if (done) ap_idle_r <= 1'b1;
    end
  end

  // read channel
  assign rd_fire = arvalid && arready;
  assign rvalid  = (rd_state == RD_DATA);
  assign rdata   = rdata_r;
  assign rresp   = OKAY;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      rd_state <= RD_IDLE;
      arready  <= 1'b0;  // held low for the first cycle out of reset
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (rd_fire) begin
            rd_state <= RD_DATA;
            arready  <= 1'b0;
          end else begin
            arready <= 1'b1;
          end
        end
        RD_DATA: begin
          if (rready) begin
            rd_state <= RD_IDLE;
            arready  <= 1'b1;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_comb begin
    stat_off = araddr - reg_stat_base;
    stat_hit = (araddr >= reg_stat_base) && (stat_off < 4 * num_stats) &&
               (araddr[1:0] == 2'b00);
    rd_mux   = '0;  // unmapped reads return zero
    case (araddr)
      reg_ctrl: begin
        rd_mux[ctrl_done_bit] = ap_done_r;
        rd_mux[ctrl_idle_bit] = ap_idle_r;
      end
      reg_time_in_cycles: rd_mux = time_in_cycles;
      reg_exec_cycles:    rd_mux = exec_cycles;
      default: begin
        if (stat_hit) rd_mux = stats.count[stat_off[2 +: stat_idx_width]];
      end
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (rd_fire) rdata_r <= rd_mux;  // held until rready
  end

endmodule

// ==== dv/tb_tcp_bench_monitor.sv ====
/*
 * testbench for the TCP benchmark monitor: AXI4-Lite register tests,
 * random stream traffic against a counting model, watchdog
 */
`timescale 1ns/10ps

module tb_tcp_bench_monitor import bench_regs_pkg::*, tcp_stats_pkg::*; ();

  localparam int clk_period      = 8;
  localparam int reset_cycles    = 16;
  localparam int traffic_cycles  = 300;
  localparam int max_txns        = 200;  // upper bound on register accesses
  localparam int txn_cycles      = 14;   // worst case per access incl. random delays
  localparam int watchdog_cycles = reset_cycles + 2 * traffic_cycles + max_txns * txn_cycles;

  logic                      ap_clk;
  logic                      ap_rst_n;
  logic                      s_axi_control_awvalid;
  logic                      s_axi_control_awready;
  logic [axi_addr_width-1:0] s_axi_control_awaddr;
  logic                      s_axi_control_wvalid;
  logic                      s_axi_control_wready;
  logic [axi_data_width-1:0] s_axi_control_wdata;
  logic [axi_strb_width-1:0] s_axi_control_wstrb;
  logic                      s_axi_control_bvalid;
  logic                      s_axi_control_bready;
  logic [1:0]                s_axi_control_bresp;
  logic                      s_axi_control_arvalid;
  logic                      s_axi_control_arready;
  logic [axi_addr_width-1:0] s_axi_control_araddr;
  logic                      s_axi_control_rvalid;
  logic                      s_axi_control_rready;
  logic [axi_data_width-1:0] s_axi_control_rdata;
  logic [1:0]                s_axi_control_rresp;
  logic                      listen_valid, listen_ready;
  logic                      open_req_valid, open_req_ready;
  logic                      open_sts_valid, open_sts_ready;
  logic [open_sts_width-1:0] open_sts_data;
  logic                      close_valid, close_ready;
  logic                      rd_req_valid, rd_req_ready;
  logic [rd_req_width-1:0]   rd_req_data;
  logic                      rx_data_valid, rx_data_ready, rx_data_last;
  logic [keep_width-1:0]     rx_data_keep;
  logic                      tx_meta_valid, tx_meta_ready;
  logic                      tx_data_valid, tx_data_ready, tx_data_last;
  logic [keep_width-1:0]     tx_data_keep;
  logic                      tx_sts_valid, tx_sts_ready;
  logic [tx_sts_width-1:0]   tx_sts_data;

  logic [stat_width-1:0] exp_stat [num_stats];  // reference counts
  int                    errors = 0;

  tcp_bench_monitor DUT (.*);

  always #(clk_period / 2) ap_clk = ~ap_clk;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [axi_addr_width-1:0] addr, input logic [31:0] data);
    int d;
    d = $urandom_range(0, 4);  // bready delay
    @(posedge ap_clk);
    s_axi_control_awvalid <= 1'b1;
    s_axi_control_awaddr  <= addr;
    s_axi_control_wvalid  <= 1'b1;
    s_axi_control_wdata   <= data;
    s_axi_control_wstrb   <= '1;
    @(negedge ap_clk);
    while (!s_axi_control_awready) @(negedge ap_clk);
    @(posedge ap_clk);
    s_axi_control_awvalid <= 1'b0;
    s_axi_control_wvalid  <= 1'b0;
    repeat (d) @(posedge ap_clk);
    s_axi_control_bready <= 1'b1;
    @(negedge ap_clk);
    while (!s_axi_control_bvalid) @(negedge ap_clk);
    compare("bresp", OKAY, s_axi_control_bresp);
    @(posedge ap_clk);
    s_axi_control_bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [axi_addr_width-1:0] addr, output logic [31:0] data);
    int d;
    d = $urandom_range(0, 4);  // rready delay
    @(posedge ap_clk);
    s_axi_control_arvalid <= 1'b1;
    s_axi_control_araddr  <= addr;
    @(negedge ap_clk);
    while (!s_axi_control_arready) @(negedge ap_clk);
    @(posedge ap_clk);
    s_axi_control_arvalid <= 1'b0;
    repeat (d) @(posedge ap_clk);
    s_axi_control_rready <= 1'b1;
    @(negedge ap_clk);
    while (!s_axi_control_rvalid) @(negedge ap_clk);
    data = s_axi_control_rdata;
    compare("rresp", OKAY, s_axi_control_rresp);
    @(posedge ap_clk);
    s_axi_control_rready <= 1'b0;
  endtask

  task automatic verify_stats(input string tag);
    logic [31:0] v;
    for (int i = 0; i < num_stats; i++) begin
      read_reg(reg_stat_base + axi_addr_width'(4 * i), v);
      compare($sformatf("%s stat %0d", tag, i), exp_stat[i], v);
    end
  endtask

  // random handshakes on every stream, counted by the model as they are driven
  task automatic drive_traffic(input int cycles);
    logic [31:0] r;
    logic [31:0] osts;
    logic [31:0] rreq;
    logic [31:0] keeps;
    logic [63:0] sts;
    for (int c = 0; c < cycles; c++) begin
      r     = $urandom();
      osts  = $urandom();
      rreq  = $urandom();
      keeps = $urandom();
      sts   = {$urandom(), $urandom()};
      @(posedge ap_clk);
      listen_valid   <= r[0];
      listen_ready   <= r[1];
      open_req_valid <= r[2];
      open_req_ready <= r[3];
      open_sts_valid <= r[4];
      open_sts_ready <= r[5];
      open_sts_data  <= osts[23:0];
      close_valid    <= r[6];
      close_ready    <= r[7];
      rd_req_valid   <= r[8];
      rd_req_ready   <= r[9];
      rd_req_data    <= rreq;
      rx_data_valid  <= r[10];
      rx_data_ready  <= r[11];
      rx_data_keep   <= keeps[7:0];
      rx_data_last   <= r[12];
      tx_meta_valid  <= r[13];
      tx_meta_ready  <= r[14];
      tx_data_valid  <= r[15];
      tx_data_ready  <= r[16];
      tx_data_keep   <= keeps[15:8];
      tx_data_last   <= r[17];
      tx_sts_valid   <= r[18];
      tx_sts_ready   <= r[19];
      tx_sts_data    <= sts;
      if (r[0] && r[1]) exp_stat[STAT_LISTEN_REQ] += 1;
      if (r[2] && r[3]) exp_stat[STAT_OPEN_REQ] += 1;
      if (r[4] && r[5]) exp_stat[STAT_OPEN_STS] += 1;
      if (r[4] && r[5] && osts[16]) exp_stat[STAT_OPEN_OK] += 1;  // established flag
      if (r[6] && r[7]) exp_stat[STAT_CLOSE_REQ] += 1;
      if (r[8] && r[9]) exp_stat[STAT_RD_REQ_BYTES] += rreq[31:16];
      if (r[10] && r[11]) exp_stat[STAT_RX_BYTES] += $countones(keeps[7:0]);
      if (r[10] && r[11] && r[12]) exp_stat[STAT_RX_PKTS] += 1;
      if (r[13] && r[14]) exp_stat[STAT_TX_CMDS] += 1;
      if (r[15] && r[16]) exp_stat[STAT_TX_BYTES] += $countones(keeps[15:8]);
      if (r[15] && r[16] && r[17]) exp_stat[STAT_TX_PKTS] += 1;
      if (r[18] && r[19]) exp_stat[STAT_TX_STS] += 1;
      if (r[18] && r[19] && sts[63:62] == 2'b00) exp_stat[STAT_TX_STS_GOOD] += 1;
    end
    @(posedge ap_clk);
    {listen_valid, open_req_valid, open_sts_valid, close_valid, rd_req_valid} <= '0;
    {rx_data_valid, tx_meta_valid, tx_data_valid, tx_sts_valid} <= '0;
    repeat (3) @(posedge ap_clk);  // let the last counts land
  endtask

  // watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] v;
    logic [31:0] time_lim;
    int          polls;
    bit          finished;
    void'($urandom(36));
    ap_clk   = 1'b0;
    ap_rst_n = 1'b0;
    {s_axi_control_awvalid, s_axi_control_wvalid, s_axi_control_bready} = '0;
    {s_axi_control_arvalid, s_axi_control_rready} = '0;
    s_axi_control_awaddr = '0;
    s_axi_control_araddr = '0;
    s_axi_control_wdata  = '0;
    s_axi_control_wstrb  = '0;
    {listen_valid, listen_ready, open_req_valid, open_req_ready} = '0;
    {open_sts_valid, open_sts_ready, close_valid, close_ready} = '0;
    {rd_req_valid, rd_req_ready, rx_data_valid, rx_data_ready, rx_data_last} = '0;
    {tx_meta_valid, tx_meta_ready, tx_data_valid, tx_data_ready, tx_data_last} = '0;
    {tx_sts_valid, tx_sts_ready} = '0;
    open_sts_data = '0;
    rd_req_data   = '0;
    rx_data_keep  = '0;
    tx_data_keep  = '0;
    tx_sts_data   = '0;
    for (int i = 0; i < num_stats; i++) exp_stat[i] = '0;
    repeat (reset_cycles) @(posedge ap_clk);
    ap_rst_n <= 1'b1;

    // first cycle out of reset: no handshake signal raised
    @(negedge ap_clk);
    compare("handshakes after reset", 32'h0,
            {s_axi_control_awready, s_axi_control_wready, s_axi_control_bvalid,
             s_axi_control_arready, s_axi_control_rvalid});

    // after reset: idle set, done clear, counters zero
    read_reg(reg_ctrl, v);
    compare("ctrl after reset", 32'h4, v);
    verify_stats("reset");

    // random traffic on all streams
    drive_traffic(traffic_cycles);
    verify_stats("traffic");

    // timed run
    time_lim = $urandom_range(8, 40);
    write_reg(reg_time_in_cycles, time_lim);
    read_reg(reg_time_in_cycles, v);
    compare("time_in_cycles", time_lim, v);
    write_reg(reg_ctrl, 32'h1);
    for (int i = 0; i < num_stats; i++) exp_stat[i] = '0;  // start clears all counts
    polls    = 0;
    finished = 0;
    while (!finished && polls < 100) begin
      read_reg(reg_ctrl, v);
      polls++;
      if (v[1]) begin
        compare("ctrl at done", 32'h6, v);
        finished = 1;
      end else begin
        compare("ctrl while running", 32'h0, v);
      end
    end
    if (!finished) begin
      $display("Run did not report done after %0d status reads", polls);
      errors++;
    end
    read_reg(reg_ctrl, v);
    compare("ctrl after done read", 32'h4, v);
    read_reg(reg_exec_cycles, v);
    compare("exec_cycles", time_lim, v);

    // counts restart from zero after the start
    verify_stats("after start");
    drive_traffic(traffic_cycles);
    verify_stats("traffic after start");

    // unmapped reads and writes to read-only registers
    read_reg(12'h004, v);
    compare("unmapped 0x004", 32'h0, v);
    read_reg(12'h018, v);
    compare("unmapped 0x018", 32'h0, v);
    read_reg(reg_stat_base + 12'(4 * num_stats), v);
    compare("past last stat", 32'h0, v);
    read_reg(reg_stat_base + 12'h2, v);
    compare("unaligned stat", 32'h0, v);
    write_reg(12'h020, $urandom());
    read_reg(12'h020, v);
    compare("unmapped write", 32'h0, v);
    read_reg(reg_time_in_cycles, v);
    compare("time_in_cycles after unmapped write", time_lim, v);
    write_reg(reg_exec_cycles, $urandom());
    read_reg(reg_exec_cycles, v);
    compare("exec_cycles after write", time_lim, v);
    for (int i = 0; i < num_stats; i++) write_reg(reg_stat_base + 12'(4 * i), $urandom());
    verify_stats("stat write");

    errors += int'(DUT.u_control.u_props.fail_count);
    $display("Checks finished: %0d errors, %0d assertion failures", errors,
             DUT.u_control.u_props.fail_count);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== dv/tcp_bench_properties.sv ====
/*
 * bound checks on the control slave: response hold,
 * start pulse width, idle versus running
 */
`timescale 1ns/10ps

module tcp_bench_properties import bench_regs_pkg::*; (
  input logic                      ap_clk,
  input logic                      ap_rst_n,
  input logic                      bvalid,
  input logic                      bready,
  input logic                      rvalid,
  input logic                      rready,
  input logic [axi_data_width-1:0] rdata,
  input logic                      start_pulse,
  input logic                      done,
  input logic                      ap_idle
);

  logic        run_q;  // mirror of the timer running flag
  int unsigned fail_count = 0;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      run_q <= 1'b0;
    end else if (start_pulse) begin
      run_q <= 1'b1;
    end else if (done) begin
      run_q <= 1'b0;
    end
  end

  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      fail_count++;
      $error("rvalid or rdata changed before rready");
    end

  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    start_pulse |=> !start_pulse)
    else begin
      fail_count++;
      $error("start pulse longer than one cycle");
    end

  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    !(ap_idle && run_q))
    else begin
      fail_count++;
      $error("ap_idle high while the run timer is running");
    end

endmodule

bind control_s_axi tcp_bench_properties u_props (
  .ap_clk      (ap_clk),
  .ap_rst_n    (ap_rst_n),
  .bvalid      (bvalid),
  .bready      (bready),
  .rvalid      (rvalid),
  .rready      (rready),
  .rdata       (rdata),
  .start_pulse (start_pulse),
  .done        (done),
  .ap_idle     (ap_idle_r)
);

// ==== filelist.f ====
common/bench_regs_pkg.sv
common/tcp_stats_pkg.sv
common/stat_bus_if.sv
control/control_s_axi.sv
source/run_timer.sv
stats/event_tap.sv
stats/stat_counter.sv
source/tcp_bench_monitor.sv
dv/tcp_bench_properties.sv
dv/tb_tcp_bench_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the TCP benchmark monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_tcp_bench_monitor \
  -f filelist.f --Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }

./obj_dir/Vtb_tcp_bench_monitor +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/run_timer.sv ====
/*
 * run timer: running flag, elapsed cycle count and done pulse
 */
`timescale 1ns/10ps

module run_timer import bench_regs_pkg::*; (
  input  logic                      ap_clk,
  input  logic                      ap_rst_n,
  input  logic                      start_pulse,
  input  logic [axi_data_width-1:0] time_in_cycles,
  output logic                      done,
  output logic [axi_data_width-1:0] exec_cycles
);

  logic running;

  // limit reached, single cycle since running drops on the same edge
  assign done = running && (exec_cycles == time_in_cycles);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      running     <= 1'b0;
      exec_cycles <= '0;
    end else begin
      if (start_pulse) begin
        running     <= 1'b1;  // restart allowed mid run
        exec_cycles <= '0;
      end else if (done) begin
        running <= 1'b0;  // count kept for readback
      end else if (running) begin
        exec_cycles <= exec_cycles + 1'b1;
      end
    end
  end

endmodule

// ==== source/tcp_bench_monitor.sv ====
/*
 * TCP benchmark monitor top: control slave, run timer,
 * stream event tap and statistics counter array
 */
`timescale 1ns/10ps

module tcp_bench_monitor import bench_regs_pkg::*, tcp_stats_pkg::*; (
  input  logic                      ap_clk,
  input  logic                      ap_rst_n,
  input  logic                      s_axi_control_awvalid,
  output logic                      s_axi_control_awready,
  input  logic [axi_addr_width-1:0] s_axi_control_awaddr,
  input  logic                      s_axi_control_wvalid,
  output logic                      s_axi_control_wready,
  input  logic [axi_data_width-1:0] s_axi_control_wdata,
  input  logic [axi_strb_width-1:0] s_axi_control_wstrb,
  output logic                      s_axi_control_bvalid,
  input  logic                      s_axi_control_bready,
  output logic [1:0]                s_axi_control_bresp,
  input  logic                      s_axi_control_arvalid,
  output logic                      s_axi_control_arready,
  input  logic [axi_addr_width-1:0] s_axi_control_araddr,
  output logic                      s_axi_control_rvalid,
  input  logic                      s_axi_control_rready,
  output logic [axi_data_width-1:0] s_axi_control_rdata,
  output logic [1:0]                s_axi_control_rresp,
  input  logic                      listen_valid,
  input  logic                      listen_ready,
  input  logic                      open_req_valid,
  input  logic                      open_req_ready,
  input  logic                      open_sts_valid,
  input  logic                      open_sts_ready,
  input  logic [open_sts_width-1:0] open_sts_data,
  input  logic                      close_valid,
  input  logic                      close_ready,
  input  logic                      rd_req_valid,
  input  logic                      rd_req_ready,
  input  logic [rd_req_width-1:0]   rd_req_data,
  input  logic                      rx_data_valid,
  input  logic                      rx_data_ready,
  input  logic [keep_width-1:0]     rx_data_keep,
  input  logic                      rx_data_last,
  input  logic                      tx_meta_valid,
  input  logic                      tx_meta_ready,
  input  logic                      tx_data_valid,
  input  logic                      tx_data_ready,
  input  logic [keep_width-1:0]     tx_data_keep,
  input  logic                      tx_data_last,
  input  logic                      tx_sts_valid,
  input  logic                      tx_sts_ready,
  input  logic [tx_sts_width-1:0]   tx_sts_data
);

  logic                      start_pulse;
  logic                      done;
  logic [axi_data_width-1:0] time_in_cycles;
  logic [axi_data_width-1:0] exec_cycles;

  stat_bus_if stats_bus ();

  control_s_axi u_control (
    .ap_clk         (ap_clk),
    .ap_rst_n       (ap_rst_n),
    .awvalid        (s_axi_control_awvalid),
    .awready        (s_axi_control_awready),
    .awaddr         (s_axi_control_awaddr),
    .wvalid         (s_axi_control_wvalid),
    .wready         (s_axi_control_wready),
    .wdata          (s_axi_control_wdata),
    .wstrb          (s_axi_control_wstrb),
    .bvalid         (s_axi_control_bvalid),
    .bready         (s_axi_control_bready),
    .bresp          (s_axi_control_bresp),
    .arvalid        (s_axi_control_arvalid),
    .arready        (s_axi_control_arready),
    .araddr         (s_axi_control_araddr),
    .rvalid         (s_axi_control_rvalid),
    .rready         (s_axi_control_rready),
    .rdata          (s_axi_control_rdata),
    .rresp          (s_axi_control_rresp),
    .done           (done),
    .exec_cycles    (exec_cycles),
    .start_pulse    (start_pulse),
    .time_in_cycles (time_in_cycles),
    .stats          (stats_bus)
  );

  run_timer u_timer (
    .ap_clk         (ap_clk),
    .ap_rst_n       (ap_rst_n),
    .start_pulse    (start_pulse),
    .time_in_cycles (time_in_cycles),
    .done           (done),
    .exec_cycles    (exec_cycles)
  );

  event_tap u_tap (
    .ap_clk         (ap_clk),
    .ap_rst_n       (ap_rst_n),
    .listen_valid   (listen_valid),
    .listen_ready   (listen_ready),
    .open_req_valid (open_req_valid),
    .open_req_ready (open_req_ready),
    .open_sts_valid (open_sts_valid),
    .open_sts_ready (open_sts_ready),
    .open_sts_data  (open_sts_data),
    .close_valid    (close_valid),
    .close_ready    (close_ready),
    .rd_req_valid   (rd_req_valid),
    .rd_req_ready   (rd_req_ready),
    .rd_req_data    (rd_req_data),
    .rx_data_valid  (rx_data_valid),
    .rx_data_ready  (rx_data_ready),
    .rx_data_keep   (rx_data_keep),
    .rx_data_last   (rx_data_last),
    .tx_meta_valid  (tx_meta_valid),
    .tx_meta_ready  (tx_meta_ready),
    .tx_data_valid  (tx_data_valid),
    .tx_data_ready  (tx_data_ready),
    .tx_data_keep   (tx_data_keep),
    .tx_data_last   (tx_data_last),
    .tx_sts_valid   (tx_sts_valid),
    .tx_sts_ready   (tx_sts_ready),
    .tx_sts_data    (tx_sts_data),
    .ev             (stats_bus)
  );

  for (genvar i = 0; i < num_stats; i++) begin : g_stat
    stat_counter u_counter (
      .ap_clk   (ap_clk),
      .ap_rst_n (ap_rst_n),
      .idx      (stat_id_e'(i)),
      .cnt      (stats_bus)
    );
  end

endmodule

// ==== stats/event_tap.sv ====
/*
 * TCP stream handshake decoder, one registered increment per statistic
 */
`timescale 1ns/10ps

module event_tap import tcp_stats_pkg::*; (
  input  logic                      ap_clk,
  input  logic                      ap_rst_n,
  input  logic                      listen_valid,
  input  logic                      listen_ready,
  input  logic                      open_req_valid,
  input  logic                      open_req_ready,
  input  logic                      open_sts_valid,
  input  logic                      open_sts_ready,
  input  logic [open_sts_width-1:0] open_sts_data,
  input  logic                      close_valid,
  input  logic                      close_ready,
  input  logic                      rd_req_valid,
  input  logic                      rd_req_ready,
  input  logic [rd_req_width-1:0]   rd_req_data,
  input  logic                      rx_data_valid,
  input  logic                      rx_data_ready,
  input  logic [keep_width-1:0]     rx_data_keep,
  input  logic                      rx_data_last,
  input  logic                      tx_meta_valid,
  input  logic                      tx_meta_ready,
  input  logic                      tx_data_valid,
  input  logic                      tx_data_ready,
  input  logic [keep_width-1:0]     tx_data_keep,
  input  logic                      tx_data_last,
  input  logic                      tx_sts_valid,
  input  logic                      tx_sts_ready,
  input  logic [tx_sts_width-1:0]   tx_sts_data,
  stat_bus_if.tap                   ev
);

  logic rx_hs;
  logic tx_hs;
  logic sts_hs;
  logic open_hs;

  // number of valid bytes in a beat
  function automatic logic [stat_width-1:0] popcount(input logic [keep_width-1:0] keep);
    logic [stat_width-1:0] n;
    n = '0;
    for (int i = 0; i < keep_width; i++) n = n + keep[i];
    return n;
  endfunction

  assign rx_hs   = rx_data_valid && rx_data_ready;
  assign tx_hs   = tx_data_valid && tx_data_ready;
  assign sts_hs  = tx_sts_valid && tx_sts_ready;
  assign open_hs = open_sts_valid && open_sts_ready;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      ev.inc_en <= '0;
    end else begin
      ev.inc_en[STAT_LISTEN_REQ]   <= listen_valid && listen_ready;
      ev.inc_en[STAT_OPEN_REQ]     <= open_req_valid && open_req_ready;
      ev.inc_en[STAT_OPEN_STS]     <= open_hs;
      ev.inc_en[STAT_OPEN_OK]      <= open_hs && open_sts_data[open_ok_bit];
      ev.inc_en[STAT_CLOSE_REQ]    <= close_valid && close_ready;
      ev.inc_en[STAT_RD_REQ_BYTES] <= rd_req_valid && rd_req_ready;
      ev.inc_en[STAT_RX_PKTS]      <= rx_hs && rx_data_last;
      ev.inc_en[STAT_RX_BYTES]     <= rx_hs;
      ev.inc_en[STAT_TX_BYTES]     <= tx_hs;
      ev.inc_en[STAT_TX_PKTS]      <= tx_hs && tx_data_last;
      ev.inc_en[STAT_TX_CMDS]      <= tx_meta_valid && tx_meta_ready;
      ev.inc_en[STAT_TX_STS]       <= sts_hs;
      ev.inc_en[STAT_TX_STS_GOOD]  <= sts_hs && (tx_sts_data[tx_err_msb:tx_err_lsb] == '0);
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < num_stats; i++) ev.inc_amount[i] <= stat_width'(1);  // event count
    ev.inc_amount[STAT_RD_REQ_BYTES] <= stat_width'(rd_req_data[rd_req_width-1:rd_len_lsb]);
    ev.inc_amount[STAT_RX_BYTES]     <= popcount(rx_data_keep);
    ev.inc_amount[STAT_TX_BYTES]     <= popcount(tx_data_keep);
  end

endmodule

// ==== stats/stat_counter.sv ====
/*
 * one accumulating statistics counter, cleared on run start
 */
`timescale 1ns/10ps

module stat_counter import tcp_stats_pkg::*; (
  input  logic       ap_clk,
  input  logic       ap_rst_n,
  input  stat_id_e   idx,  // tied to the generate index
  stat_bus_if.counter cnt
);

  // each instance owns only its own element of the count array
  always @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      cnt.count[idx] <= '0;
    end else if (cnt.clear) begin
      cnt.count[idx] <= '0;  // clear wins over a same-cycle increment
    end else if (cnt.inc_en[idx]) begin
      cnt.count[idx] <= cnt.count[idx] + cnt.inc_amount[idx];
    end
  end

endmodule
